// ==== list.f ====
verilog/decode_pkg.sv
verilog/branch_decoder.sv
verilog/alu_decoder.sv
verilog/lsu_decoder.sv
verilog/wired_decoder.sv
testbench/wired_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -f list.f \
    --top-module wired_decoder_tb -o sim_wired_decoder
./obj_dir/sim_wired_decoder | tee sim.log
if grep -q "Verification failed" sim.log; then
    echo "Simulation reported a failure, see sim.log."
    exit 1
fi
echo "Simulation finished without failures."
exit 0

// ==== testbench/decode_trace.txt ====
# Columns: instruction, expected decode_err, expected decode_t fields (packed, MSB first), name.
# All values are hex. Rows of one opcode vary only the register and immediate bits.
4c000041 0 0228ac20 jirl
4ffffc23 0 0228ac20 jirl_hi
50000400 0 02000020 b
53ffffff 0 02000020 b_hi
54000010 0 02102820 bl
57ffffff 0 02102820 bl_hi
58001085 0 02a08060 beq
5c00a4c6 0 02a080a0 bne
60000c41 0 02a080e0 blt
6403fc87 0 02a08120 bge
68001ca5 0 02a08160 bltu
6fffffe0 0 02a081a0 bgeu
14000004 0 02ce2000 lu12i
15ffffe7 0 02ce2000 lu12i_hi
1c000021 0 02ce3000 pcaddu12i
02001884 0 02ea5000 slti
023ffc25 0 02ea5000 slti_hi
0240118c 0 02ea5800 sltui
02800421 0 02ea4000 addi
02bfffff 0 02ea4000 addi_hi
03400c63 0 02ec0800 andi
038010a5 0 02ec1000 ori
03ffffe7 0 02ec1800 xori
2ac00000 0 02000000 preld
2ac0801f 0 02000000 preld_hi
00101ca4 0 02684000 add
00107fff 0 02684000 add_hi
00110c41 0 02684800 sub
001218c6 0 02685000 slt
00129483 0 02685800 sltu
00140c00 0 02680000 nor
0014a4e7 0 02680800 and
00151085 0 02681000 or
0015ffff 0 02681800 xor
00170c41 0 02686000 sll
00179c62 0 02686800 srl
00181483 0 02687000 sra
00408c41 0 02e86000 slli
0044fc85 0 02e86800 srli
0048ffff 0 02e87000 srai
28000c41 0 01290001 ld_b
284010a5 0 01290005 ld_h
28800000 0 01290009 ld_w
28bfffff 0 01290009 ld_w_hi
2a001085 0 0129000d ld_bu
2a7fffff 0 01290011 ld_hu
29000c41 0 01a10002 st_b
294018c6 0 01a10006 st_h
29800000 0 01a1000a st_w
2980a4c6 0 01a1000a st_w_hi
00000000 1 00000000 all_zero
001c0000 1 00000000 mul_w
001c7fff 1 00000000 mul_w_hi
00200c41 1 00000000 div_w
20000c41 1 00000000 ll_w
21001085 1 00000000 sc_w
06000c41 1 00000000 cacop
38720000 1 00000000 dbar
38728000 1 00000000 ibar

// ==== testbench/wired_decoder_tb.sv ====
`timescale 1ns/10ps

module wired_decoder_tb import decode_pkg::*; ();

    localparam string TRACE_FILE   = "testbench/decode_trace.txt";
    localparam int    RANDOM_COUNT = 200;
    localparam int    CLK_PERIOD   = 100;

    logic       clk;
    logic       arst_n;
    inst_t      inst;
    logic       decode_err;
    logic       alu_inst, lsu_inst, jump_inst, mem_write, mem_read;
    reg_r0_t    reg_type_r0;
    reg_r1_t    reg_type_r1;
    reg_w_t     reg_type_w;
    imm_t       imm_type;
    addr_imm_t  addr_imm_type;
    alu_gtype_t alu_grand_op;
    alu_stype_t alu_op;
    target_t    target_type;
    cmp_t       cmp_type;
    mem_t       mem_type;
    decode_t    dut_fields;

    logic [31:0] trace_inst [$];
    logic [31:0] trace_err [$];
    logic [31:0] trace_fields [$];
    string       trace_name [$];
    logic        trace_loaded = 1'b0;
    logic [31:0] lfsr_state = 32'd89362;
    int          check_count = 0;
    int          error_count = 0;

    wired_decoder wired_decoder_inst (
        .inst_i(inst), .decode_err_o(decode_err),
        .alu_inst_o(alu_inst), .lsu_inst_o(lsu_inst),
        .reg_type_r0_o(reg_type_r0), .reg_type_r1_o(reg_type_r1),
        .reg_type_w_o(reg_type_w), .imm_type_o(imm_type),
        .addr_imm_type_o(addr_imm_type), .alu_grand_op_o(alu_grand_op),
        .alu_op_o(alu_op), .target_type_o(target_type), .cmp_type_o(cmp_type),
        .jump_inst_o(jump_inst), .mem_type_o(mem_type),
        .mem_write_o(mem_write), .mem_read_o(mem_read)
    );

    // Same bit order as decode_t.
    assign dut_fields = {alu_inst, lsu_inst, reg_type_r0, reg_type_r1, reg_type_w, imm_type,
                         addr_imm_type, alu_grand_op, alu_op, target_type, cmp_type,
                         jump_inst, mem_type, mem_write, mem_read};

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // Taps 32, 22, 2, 1.
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // Opcode bits that must stay fixed for a given base instruction.
    function automatic logic [31:0] opcode_mask(input logic [31:0] word);
        logic [31:0] mask;
        if (word[31:26] >= 6'b010011 && word[31:26] <= 6'b011011) begin
            mask = 32'hfc00_0000; // Jumps and branches.
        end else if (word[31:25] == 7'b0001010 || word[31:25] == 7'b0001110) begin
            mask = 32'hfe00_0000;
        end else if (word[31:23] == 9'd0) begin
            mask = 32'hffff_8000; // 17-bit forms.
        end else begin
            mask = 32'hffc0_0000;
        end
        return mask;
    endfunction

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic apply_and_check(input logic [31:0] word, input logic [31:0] exp_err,
                                   input logic [31:0] exp_fields, input string test_name);
        @(posedge clk);
        inst <= word;
        @(negedge clk);
        check_value({test_name, " decode_err"}, exp_err, {31'd0, decode_err});
        check_value({test_name, " fields"}, exp_fields, {6'd0, dut_fields});
    endtask

    task automatic load_trace();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [31:0] inst_word;
        logic [31:0] err_word;
        logic [31:0] field_word;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: the trace file %s could not be opened.", TRACE_FILE);
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != 8'h23) begin // Skip # lines.
                    code = $sscanf(line, "%h %h %h %s", inst_word, err_word, field_word, name);
                    if (code == 4) begin
                        trace_inst.push_back(inst_word);
                        trace_err.push_back(err_word);
                        trace_fields.push_back(field_word);
                        trace_name.push_back(name);
                    end
                end
            end
            $fclose(fd);
            if (trace_inst.size() == 0) begin
                $display("ERROR: the trace file holds no test rows.");
                error_count++;
            end
        end
    endtask

    task automatic run_random();
        int          row;
        logic [31:0] bits;
        logic [31:0] mask;
        logic [31:0] word;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            row = i % trace_inst.size();
            take_bits(26, bits);
            mask = opcode_mask(trace_inst[row]);
            word = (trace_inst[row] & mask) | (bits & ~mask);
            apply_and_check(word, trace_err[row], trace_fields[row],
                            $sformatf("random %0d %s", i, trace_name[row]));
        end
    endtask

    initial begin : watchdog
        wait (trace_loaded);
        #((trace_inst.size() + RANDOM_COUNT + 20) * CLK_PERIOD);
        $display("ERROR: the simulation timed out before all tests finished.");
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        inst <= '0;
        arst_n <= 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        wait (arst_n);
        for (int i = 0; i < trace_inst.size(); i++) begin
            apply_and_check(trace_inst[i], trace_err[i], trace_fields[i], trace_name[i]);
        end
        if (trace_inst.size() > 0) begin
            run_random();
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog/wired_decoder.sv ====
`timescale 1ns/10ps

module wired_decoder import decode_pkg::*; (
    input  inst_t      inst_i,
    output logic       decode_err_o,
    output logic       alu_inst_o,
    output logic       lsu_inst_o,
    output reg_r0_t    reg_type_r0_o,
    output reg_r1_t    reg_type_r1_o,
    output reg_w_t     reg_type_w_o,
    output imm_t       imm_type_o,
    output addr_imm_t  addr_imm_type_o,
    output alu_gtype_t alu_grand_op_o,
    output alu_stype_t alu_op_o,
    output target_t    target_type_o,
    output cmp_t       cmp_type_o,
    output logic       jump_inst_o,
    output mem_t       mem_type_o,
    output logic       mem_write_o,
    output logic       mem_read_o
);

    logic    branch_hit, alu_hit, lsu_hit;
    decode_t branch_dec, alu_dec, lsu_dec;
    decode_t dec_sel;

    branch_decoder branch_decoder_inst (.inst_i(inst_i), .hit_o(branch_hit), .dec_o(branch_dec));
    alu_decoder    alu_decoder_inst    (.inst_i(inst_i), .hit_o(alu_hit),    .dec_o(alu_dec));
    lsu_decoder    lsu_decoder_inst    (.inst_i(inst_i), .hit_o(lsu_hit),    .dec_o(lsu_dec));

    // Opcode spaces are disjoint, at most one hit.
    always_comb begin
        dec_sel = DECODE_DEFAULT;
        if (branch_hit) begin
            dec_sel = branch_dec;
        end else if (alu_hit) begin
            dec_sel = alu_dec;
        end else if (lsu_hit) begin
            dec_sel = lsu_dec;
        end
    end

    assign decode_err_o    = ~(branch_hit | alu_hit | lsu_hit); // Unknown opcode.
    assign alu_inst_o      = dec_sel.alu_inst;
    assign lsu_inst_o      = dec_sel.lsu_inst;
    assign reg_type_r0_o   = dec_sel.reg_type_r0;
    assign reg_type_r1_o   = dec_sel.reg_type_r1;
    assign reg_type_w_o    = dec_sel.reg_type_w;
    assign imm_type_o      = dec_sel.imm_type;
    assign addr_imm_type_o = dec_sel.addr_imm_type;
    assign alu_grand_op_o  = dec_sel.alu_grand_op;
    assign alu_op_o        = dec_sel.alu_op;
    assign target_type_o   = dec_sel.target_type;
    assign cmp_type_o      = dec_sel.cmp_type;
    assign jump_inst_o     = dec_sel.jump_inst;
    assign mem_type_o      = dec_sel.mem_type;
    assign mem_write_o     = dec_sel.mem_write;
    assign mem_read_o      = dec_sel.mem_read;

endmodule

// ==== verilog/lsu_decoder.sv ====
`timescale 1ns/10ps

module lsu_decoder import decode_pkg::*; (
    input  inst_t   inst_i,
    output logic    hit_o,
    output decode_t dec_o
);

    always_comb begin
        hit_o = 1'b0;
        dec_o = DECODE_DEFAULT;
        casez (inst_i[31:22])
            10'b0010100000,
            10'b0010100001,
            10'b0010100010: begin // LD.B, LD.H, LD.W.
                hit_o = 1'b1;
                dec_o.reg_type_w = REG_W_RD;
                dec_o.mem_type = mem_t'({1'b0, inst_i[23:22]});
                dec_o.mem_read = 1'b1;
            end
            10'b0010101000,
            10'b0010101001: begin
                hit_o = 1'b1;
                dec_o.reg_type_w = REG_W_RD;
                dec_o.mem_type = inst_i[22] ? MEM_TYPE_UHALF : MEM_TYPE_UBYTE;
                dec_o.mem_read = 1'b1;
            end
            10'b0010100100,
            10'b0010100101,
            10'b0010100110: begin
                hit_o = 1'b1;
                dec_o.reg_type_r0 = REG_R0_RD; // Store data.
                dec_o.mem_type = mem_t'({1'b0, inst_i[23:22]});
                dec_o.mem_write = 1'b1;
            end
            default: begin
                hit_o = 1'b0;
            end
        endcase

        // Address is always rj plus si12.
        if (hit_o) begin
            dec_o.lsu_inst = 1'b1;
            dec_o.reg_type_r1 = REG_R1_RJ;
            dec_o.addr_imm_type = ADDR_IMM_S12;
        end
    end

endmodule

// ==== verilog/alu_decoder.sv ====
`timescale 1ns/10ps

module alu_decoder import decode_pkg::*; (
    input  inst_t   inst_i,
    output logic    hit_o,
    output decode_t dec_o
);

    // Operand format, shared by several opcodes.
    typedef enum logic [2:0] {
        FMT_NONE, FMT_HINT, FMT_LI, FMT_SI12, FMT_UI12, FMT_RR, FMT_UI5
    } fmt_t;

    fmt_t fmt;

    always_comb begin
        fmt = FMT_NONE;
        dec_o = DECODE_DEFAULT;
        casez (inst_i[31:15])
            17'b0001010_??????????: begin // LU12I.
                fmt = FMT_LI;
                dec_o.alu_grand_op = ALU_GTYPE_LI;
                dec_o.alu_op = ALU_STYPE_LUI;
            end
            17'b0001110_??????????: begin // PCADDU12I.
                fmt = FMT_LI;
                dec_o.alu_grand_op = ALU_GTYPE_LI;
                dec_o.alu_op = ALU_STYPE_PCADDUI;
            end
            17'b0000001000_???????,
            17'b0000001001_???????,
            17'b0000001010_???????: begin
                fmt = FMT_SI12;
                dec_o.alu_grand_op = ALU_GTYPE_INT;
                case (inst_i[23:22])
                    2'b00:   dec_o.alu_op = ALU_STYPE_SLT;
                    2'b01:   dec_o.alu_op = ALU_STYPE_SLTU;
                    default: dec_o.alu_op = ALU_STYPE_ADD;
                endcase
            end
            17'b0000001101_???????,
            17'b0000001110_???????,
            17'b0000001111_???????: begin
                fmt = FMT_UI12;
                dec_o.alu_grand_op = ALU_GTYPE_BW;
                dec_o.alu_op = inst_i[23:22]; // 01 AND, 10 OR, 11 XOR.
            end
            17'b0010101011_???????: begin
                fmt = FMT_HINT; // Prefetch, executes as a no-op.
            end
            17'b00000000000100000,
            17'b00000000000100010,
            17'b00000000000100100,
            17'b00000000000100101: begin
                fmt = FMT_RR;
                dec_o.alu_grand_op = ALU_GTYPE_INT;
                case (inst_i[17:15])
                    3'b000:  dec_o.alu_op = ALU_STYPE_ADD;
                    3'b010:  dec_o.alu_op = ALU_STYPE_SUB;
                    3'b100:  dec_o.alu_op = ALU_STYPE_SLT;
                    default: dec_o.alu_op = ALU_STYPE_SLTU;
                endcase
            end
            17'b000000000001010??: begin
                fmt = FMT_RR;
                dec_o.alu_grand_op = ALU_GTYPE_BW;
                dec_o.alu_op = inst_i[16:15]; // Same order as the ALU.
            end
            17'b00000000000101110,
            17'b00000000000101111,
            17'b00000000000110000: begin
                fmt = FMT_RR;
                dec_o.alu_grand_op = ALU_GTYPE_SFT;
                case (inst_i[17:15])
                    3'b110:  dec_o.alu_op = ALU_STYPE_SLL;
                    3'b111:  dec_o.alu_op = ALU_STYPE_SRL;
                    default: dec_o.alu_op = ALU_STYPE_SRA;
                endcase
            end
            17'b00000000010000001,
            17'b00000000010001001,
            17'b00000000010010001: begin
                fmt = FMT_UI5;
                dec_o.alu_grand_op = ALU_GTYPE_SFT;
                dec_o.alu_op = inst_i[19:18]; // 00 SLL, 01 SRL, 10 SRA.
            end
            default: begin
                fmt = FMT_NONE;
            end
        endcase

        case (fmt)
            FMT_LI: begin
                dec_o.reg_type_r0 = REG_R0_IMM;
                dec_o.reg_type_w = REG_W_RD;
                dec_o.imm_type = IMM_S20;
            end
            FMT_SI12, FMT_UI12, FMT_UI5: begin
                dec_o.reg_type_r0 = REG_R0_IMM;
                dec_o.reg_type_r1 = REG_R1_RJ;
                dec_o.reg_type_w = REG_W_RD;
                dec_o.imm_type = (fmt == FMT_SI12) ? IMM_S12 :
                                 (fmt == FMT_UI12) ? IMM_U12 : IMM_U5;
            end
            FMT_RR: begin
                dec_o.reg_type_r0 = REG_R0_RK;
                dec_o.reg_type_r1 = REG_R1_RJ;
                dec_o.reg_type_w = REG_W_RD;
            end
            default: begin
                dec_o.reg_type_r0 = REG_R0_NONE;
            end
        endcase

        hit_o = (fmt != FMT_NONE);
        dec_o.alu_inst = hit_o;
    end

endmodule

// ==== verilog/branch_decoder.sv ====
`timescale 1ns/10ps

module branch_decoder import decode_pkg::*; (
    input  inst_t   inst_i,
    output logic    hit_o,
    output decode_t dec_o
);

    always_comb begin
        hit_o = 1'b0;
        dec_o = DECODE_DEFAULT;
        casez (inst_i[31:26])
            6'b010011: begin // JIRL.
                hit_o = 1'b1;
                dec_o.reg_type_r1 = REG_R1_RJ;
                dec_o.reg_type_w = REG_W_RD;
                dec_o.addr_imm_type = ADDR_IMM_S16;
                dec_o.alu_grand_op = ALU_GTYPE_LI;
                dec_o.alu_op = ALU_STYPE_PCPLUS4;
                dec_o.target_type = TARGET_ABS;
            end
            6'b010100: begin // B.
                hit_o = 1'b1;
                dec_o.addr_imm_type = ADDR_IMM_S26;
                dec_o.target_type = TARGET_REL;
            end
            6'b010101: begin // BL.
                hit_o = 1'b1;
                dec_o.reg_type_w = REG_W_BL1;
                dec_o.addr_imm_type = ADDR_IMM_S26;
                dec_o.alu_grand_op = ALU_GTYPE_LI;
                dec_o.alu_op = ALU_STYPE_PCPLUS4;
                dec_o.target_type = TARGET_REL;
            end
            6'b010110, 6'b010111, 6'b011000,
            6'b011001, 6'b011010, 6'b011011: begin
                hit_o = 1'b1;
                dec_o.reg_type_r0 = REG_R0_RD;
                dec_o.reg_type_r1 = REG_R1_RJ;
                dec_o.addr_imm_type = ADDR_IMM_S16;
                dec_o.target_type = TARGET_REL;
                // Low opcode bits pick the condition.
                case (inst_i[28:26])
                    3'b110:  dec_o.cmp_type = CMP_E;
                    3'b111:  dec_o.cmp_type = CMP_NE;
                    3'b000:  dec_o.cmp_type = CMP_LT;
                    3'b001:  dec_o.cmp_type = CMP_GE;
                    3'b010:  dec_o.cmp_type = CMP_LTU;
                    default: dec_o.cmp_type = CMP_GEU;
                endcase
            end
            default: begin
                hit_o = 1'b0;
            end
        endcase
        dec_o.alu_inst = hit_o;  // Target computed in the ALU.
        dec_o.jump_inst = hit_o;
    end

endmodule

// ==== verilog/decode_pkg.sv ====
package decode_pkg;

    typedef logic [31:0] inst_t;

    typedef enum logic [1:0] {
        REG_R0_NONE,
        REG_R0_RK,
        REG_R0_RD,
        REG_R0_IMM
    } reg_r0_t;

    typedef enum logic {
        REG_R1_NONE,
        REG_R1_RJ
    } reg_r1_t;

    typedef enum logic [1:0] {
        REG_W_NONE,
        REG_W_RD,
        REG_W_BL1 // Link register r1.
    } reg_w_t;

    typedef enum logic [1:0] {IMM_U5, IMM_S12, IMM_U12, IMM_S20} imm_t;

    typedef enum logic [1:0] {ADDR_IMM_S26, ADDR_IMM_S16, ADDR_IMM_S12, ADDR_IMM_S14} addr_imm_t;

    typedef enum logic [1:0] {ALU_GTYPE_BW, ALU_GTYPE_LI, ALU_GTYPE_INT, ALU_GTYPE_SFT} alu_gtype_t;

    // Sub-operation codes overlap between groups.
    typedef logic [1:0] alu_stype_t;
    localparam alu_stype_t ALU_STYPE_NOR     = 2'd0;
    localparam alu_stype_t ALU_STYPE_AND     = 2'd1;
    localparam alu_stype_t ALU_STYPE_OR      = 2'd2;
    localparam alu_stype_t ALU_STYPE_XOR     = 2'd3;
    localparam alu_stype_t ALU_STYPE_LUI     = 2'd0;
    localparam alu_stype_t ALU_STYPE_PCPLUS4 = 2'd1;
    localparam alu_stype_t ALU_STYPE_PCADDUI = 2'd2;
    localparam alu_stype_t ALU_STYPE_ADD     = 2'd0;
    localparam alu_stype_t ALU_STYPE_SUB     = 2'd1;
    localparam alu_stype_t ALU_STYPE_SLT     = 2'd2;
    localparam alu_stype_t ALU_STYPE_SLTU    = 2'd3;
    localparam alu_stype_t ALU_STYPE_SLL     = 2'd0;
    localparam alu_stype_t ALU_STYPE_SRL     = 2'd1;
    localparam alu_stype_t ALU_STYPE_SRA     = 2'd2;

    typedef enum logic {TARGET_REL, TARGET_ABS} target_t;

    typedef enum logic [3:0] {
        CMP_NOCONDITION, CMP_E, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_t;

    typedef enum logic [2:0] {
        MEM_TYPE_BYTE, MEM_TYPE_HALF, MEM_TYPE_WORD, MEM_TYPE_UBYTE, MEM_TYPE_UHALF
    } mem_t;

    typedef struct packed {
        logic       alu_inst;
        logic       lsu_inst;
        reg_r0_t    reg_type_r0;
        reg_r1_t    reg_type_r1;
        reg_w_t     reg_type_w;
        imm_t       imm_type;
        addr_imm_t  addr_imm_type;
        alu_gtype_t alu_grand_op;
        alu_stype_t alu_op;
        target_t    target_type;
        cmp_t       cmp_type;
        logic       jump_inst;
        mem_t       mem_type;
        logic       mem_write;
        logic       mem_read;
    } decode_t;

    localparam decode_t DECODE_DEFAULT = '{
        alu_inst: 1'b0, lsu_inst: 1'b0,
        reg_type_r0: REG_R0_NONE, reg_type_r1: REG_R1_NONE, reg_type_w: REG_W_NONE,
        imm_type: IMM_U5, addr_imm_type: ADDR_IMM_S26,
        alu_grand_op: ALU_GTYPE_BW, alu_op: 2'd0, target_type: TARGET_REL,
        cmp_type: CMP_NOCONDITION, jump_inst: 1'b0,
        mem_type: MEM_TYPE_BYTE, mem_write: 1'b0, mem_read: 1'b0
    };

endpackage
